//--- dv/byte_buf_cases.txt
# name base len ovr ovr_addr ovr_data status restart, numbers in hex
# with ovr set the word at ovr_addr gets ovr_data just before the stream
base0_len32      00 20 0 00 0000 2 0
wrap_127_len3    7f 03 0 00 0000 2 0
wrap_len200      05 c8 0 00 0000 2 0
overwrite_mid    13 06 1 0a beef 2 0
overwrite_edge   7e 04 1 3f 1234 2 0
zero_len         20 00 0 00 0000 2 0
restart_busy     30 08 0 00 0000 2 1
long_from_40     40 80 0 00 0000 2 0

//--- src.f
design/buf_pkg.sv
design/buf_regs_pkg.sv
design/simple_dp_ram.sv
design/asym_ram.sv
design/cfg_if.sv
design/buf_regs.sv
design/byte_reader.sv
design/byte_buf_top.sv
dv/tb_clk_gen.sv
dv/byte_buf_tb.sv

//--- Bender.yml
package:
  name: byte_buf

sources:
  - design/buf_pkg.sv
  - design/buf_regs_pkg.sv
  - design/simple_dp_ram.sv
  - design/asym_ram.sv
  - design/cfg_if.sv
  - design/buf_regs.sv
  - design/byte_reader.sv
  - design/byte_buf_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/byte_buf_tb.sv

//--- dv/byte_buf_tb.sv
`timescale 1ns/10ps
`default_nettype none

module byte_buf_tb;
   import buf_pkg::*;
   import buf_regs_pkg::*;

   localparam int MAX_CASES = 32;
   localparam int N_BYTES   = 2**R_ADDR_W;

   logic                  r_clk;
   logic                  rst_n;
   logic                  w_en;
   logic [W_ADDR_W-1:0]   w_addr;
   logic [W_DATA_W-1:0]   w_data;
   logic                  cfg_we;
   logic [CFG_ADDR_W-1:0] cfg_addr;
   logic [CFG_DATA_W-1:0] cfg_wdata;
   logic [CFG_DATA_W-1:0] cfg_rdata;
   logic                  out_valid;
   logic [R_DATA_W-1:0]   out_data;

   // byte view of the memory, low half at the even address
   logic [R_DATA_W-1:0]   model [N_BYTES];

   logic [8*24-1:0]       case_name [MAX_CASES];
   int                    c_base [MAX_CASES];
   int                    c_len [MAX_CASES];
   int                    c_ovr [MAX_CASES];
   int                    c_oaddr [MAX_CASES];
   int                    c_odata [MAX_CASES];
   int                    c_status [MAX_CASES];
   int                    c_restart [MAX_CASES];

   int                    n_cases = 0;
   int                    n_pass = 0;
   int                    n_fail = 0;
   int                    test_errs = 0;
   int                    cycle_cnt = 0;
   int                    cycle_limit = 1000;
   integer                seed;

   tb_clk_gen #(.PERIOD_NS(100)) clk_inst (.r_clk(r_clk));

   byte_buf_top byte_buf_top_inst (
      .r_clk     (r_clk),
      .rst_n     (rst_n),
      .w_en      (w_en),
      .w_addr    (w_addr),
      .w_data    (w_data),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   task load_cases();
      integer           fd;
      logic [8*160-1:0] line;
      logic [8*24-1:0]  name;
      int               b, l, ov, oa, od, st, rs;
      fd = $fopen("dv/byte_buf_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open dv/byte_buf_cases.txt");
         n_fail++;
      end else begin
         // comment and blank lines do not parse into all eight columns
         while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s %h %h %h %h %h %h %h", name, b, l, ov, oa, od, st, rs) == 8
                && n_cases < MAX_CASES) begin
               case_name[n_cases] = name;
               c_base[n_cases]    = b;
               c_len[n_cases]     = l;
               c_ovr[n_cases]     = ov;
               c_oaddr[n_cases]   = oa;
               c_odata[n_cases]   = od;
               c_status[n_cases]  = st;
               c_restart[n_cases] = rs;
               n_cases++;
            end
         end
         $fclose(fd);
      end
   endtask

   task report_value(input string sig, input logic [31:0] exp_val, input logic [31:0] act_val);
      $display("error at %0t ns: %0s expected %0h got %0h", $time, sig, exp_val, act_val);
      test_errs++;
   endtask

   task write_word(input int addr, input logic [W_DATA_W-1:0] data);
      @(posedge r_clk);
      w_en   <= 1'b1;
      w_addr <= addr[W_ADDR_W-1:0];
      w_data <= data;
      @(posedge r_clk);
      w_en   <= 1'b0;
      model[2*addr]   = data[R_DATA_W-1:0];
      model[2*addr+1] = data[W_DATA_W-1:R_DATA_W];
   endtask

   task cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
      @(posedge r_clk);
      cfg_we    <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      @(posedge r_clk);
      cfg_we    <= 1'b0;
   endtask

   task read_reg(input logic [CFG_ADDR_W-1:0] addr, output logic [CFG_DATA_W-1:0] data);
      @(posedge r_clk);
      cfg_addr <= addr;
      @(negedge r_clk);
      data = cfg_rdata;
   endtask

   task fill_memory();
      logic [W_DATA_W-1:0] word;
      for (int w = 0; w < 2**W_ADDR_W; w++) begin
         word = W_DATA_W'($random(seed));
         write_word(w, word);
      end
   endtask

   task run_case(input int idx);
      int                    k;
      int                    got;
      int                    last_k;
      int                    tail;
      int                    exp_done_k;
      int                    base;
      int                    len;
      bit                    seen_done;
      logic [CFG_DATA_W-1:0] rd;
      base      = c_base[idx];
      len       = c_len[idx];
      test_errs = 0;
      if (c_ovr[idx] != 0) begin
         write_word(c_oaddr[idx], W_DATA_W'(c_odata[idx]));
      end
      cfg_write(REG_BASE, CFG_DATA_W'(base));
      cfg_write(REG_LEN, CFG_DATA_W'(len));
      cfg_write(REG_CTRL, CFG_DATA_W'(1 << CTRL_START_BIT));
      // now at the start write edge
      cfg_addr   <= REG_STATUS;
      k          = 0;
      got        = 0;
      last_k     = 0;
      tail       = 0;
      seen_done  = 1'b0;
      exp_done_k = (len == 0) ? 1 : len + 1;
      while (!seen_done || tail < 4) begin
         @(posedge r_clk);
         k++;
         if (c_restart[idx] != 0 && k == 2) begin
            cfg_we    <= 1'b1;
            cfg_addr  <= REG_CTRL;
            cfg_wdata <= CFG_DATA_W'(1 << CTRL_START_BIT);
         end
         if (c_restart[idx] != 0 && k == 3) begin
            cfg_we   <= 1'b0;
            cfg_addr <= REG_STATUS;
         end
         @(negedge r_clk);
         if (k == 1 && cfg_rdata[STAT_BUSY_BIT] !== (len != 0)) begin
            report_value("cfg_rdata busy", len != 0, cfg_rdata[STAT_BUSY_BIT]);
         end
         if (out_valid === 1'b1) begin
            if (got == 0 && k != 2) begin
               $display("first byte came %0d cycles after start, not 2", k);
               test_errs++;
            end
            if (got > 0 && k != last_k + 1) begin
               $display("gap in the byte stream before byte %0d", got);
               test_errs++;
            end
            if (got >= len) begin
               $display("extra byte beyond the programmed length at %0t ns", $time);
               test_errs++;
            end else if (out_data !== model[(base + got) % N_BYTES]) begin
               report_value("out_data", model[(base + got) % N_BYTES], out_data);
            end
            got++;
            last_k = k;
         end
         if (seen_done) begin
            tail++;
         end else if (cfg_addr == REG_STATUS && cfg_rdata[STAT_DONE_BIT] === 1'b1) begin
            seen_done = 1'b1;
            if (k != exp_done_k) begin
               $display("done rose %0d cycles after start, expected %0d", k, exp_done_k);
               test_errs++;
            end
         end
      end
      if (got != len) begin
         report_value("out_valid count", len, got);
      end
      if (cfg_rdata !== CFG_DATA_W'(c_status[idx])) begin
         report_value("cfg_rdata status", c_status[idx], cfg_rdata);
      end
      read_reg(REG_BASE, rd);
      if (rd !== CFG_DATA_W'(base)) begin
         report_value("cfg_rdata base", base, rd);
      end
      read_reg(REG_LEN, rd);
      if (rd !== CFG_DATA_W'(len)) begin
         report_value("cfg_rdata len", len, rd);
      end
      @(posedge r_clk);
      cfg_addr <= REG_STATUS;
      if (test_errs == 0) begin
         n_pass++;
         $display("test %0s passed, %0d bytes", case_name[idx], got);
      end else begin
         n_fail++;
         $display("test %0s failed with %0d errors", case_name[idx], test_errs);
      end
   endtask

   // run limit scales with the number of cases
   initial begin
      while (cycle_cnt < cycle_limit) begin
         @(posedge r_clk);
         cycle_cnt++;
      end
      $display("run stopped after %0d cycles, a stream never finished", cycle_cnt);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      rst_n     <= 1'b0;
      w_en      <= 1'b0;
      w_addr    <= '0;
      w_data    <= '0;
      cfg_we    <= 1'b0;
      cfg_addr  <= REG_STATUS;
      cfg_wdata <= '0;
      seed      = 40338;
      load_cases();
      cycle_limit = n_cases * 300 + 1000;
      repeat (5) @(posedge r_clk);
      rst_n <= 1'b1;
      fill_memory();
      for (int i = 0; i < n_cases; i++) begin
         run_case(i);
      end
      if (n_cases == 0) begin
         $display("no test cases were read");
         n_fail++;
      end
      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic r_clk
);

   initial begin
      r_clk = 1'b0;
      forever #(PERIOD_NS / 2) r_clk = ~r_clk;
   end

endmodule

`default_nettype wire

//--- design/byte_buf_top.sv
`timescale 1ns/10ps
`default_nettype none

module byte_buf_top (
   input  logic                                r_clk,
   input  logic                                rst_n,
   input  logic                                w_en,
   input  logic [buf_pkg::W_ADDR_W-1:0]        w_addr,
   input  logic [buf_pkg::W_DATA_W-1:0]        w_data,
   input  logic                                cfg_we,
   input  logic [buf_regs_pkg::CFG_ADDR_W-1:0] cfg_addr,
   input  logic [buf_regs_pkg::CFG_DATA_W-1:0] cfg_wdata,
   output logic [buf_regs_pkg::CFG_DATA_W-1:0] cfg_rdata,
   output logic                                out_valid,
   output logic [buf_pkg::R_DATA_W-1:0]        out_data
);
   import buf_pkg::*;
   import buf_regs_pkg::*;

   logic                r_en;
   logic [R_ADDR_W-1:0] r_addr;
   logic [R_DATA_W-1:0] r_data;

   cfg_if cfg_bus ();

   buf_regs regs_inst (
      .r_clk     (r_clk),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_addr  (reg_addr_e'(cfg_addr)),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg_bus.regs)
   );

   byte_reader reader_inst (
      .r_clk     (r_clk),
      .rst_n     (rst_n),
      .cfg       (cfg_bus.reader),
      .r_en      (r_en),
      .r_addr    (r_addr),
      .r_data    (r_data),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   // wide write side, byte read side
   asym_ram #(
      .W_DATA_W (W_DATA_W),
      .W_ADDR_W (W_ADDR_W),
      .R_DATA_W (R_DATA_W),
      .R_ADDR_W (R_ADDR_W)
   ) ram_inst (
      .r_clk  (r_clk),
      .rst_n  (rst_n),
      .w_en   (w_en),
      .w_data (w_data),
      .w_addr (w_addr),
      .r_en   (r_en),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

`default_nettype wire

//--- design/byte_reader.sv
`timescale 1ns/10ps
`default_nettype none

module byte_reader (
   input  logic                          r_clk,
   input  logic                          rst_n,
   cfg_if.reader                         cfg,
   output logic                          r_en,
   output logic [buf_pkg::R_ADDR_W-1:0]  r_addr,
   input  logic [buf_pkg::R_DATA_W-1:0]  r_data,
   output logic                          out_valid,
   output logic [buf_pkg::R_DATA_W-1:0]  out_data
);
   import buf_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      READ,
      FINISH
   } state_e;

   state_e              state_q;
   logic [R_ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]    cnt_q;
   logic                done_q;
   logic                valid_q;

   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
         addr_q  <= '0;
         cnt_q   <= '0;
         done_q  <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         // ram data lands one cycle after the read
         valid_q <= r_en;
         case (state_q)
            IDLE: begin
               if (cfg.start) begin
                  addr_q <= cfg.base;
                  cnt_q  <= cfg.len;
                  if (cfg.len == '0) begin
                     state_q <= FINISH;
                     done_q  <= 1'b1;
                  end else begin
                     state_q <= READ;
                     done_q  <= 1'b0;
                  end
               end
            end
            READ: begin
               // address wraps modulo the byte space
               addr_q <= addr_q + 1'b1;
               cnt_q  <= cnt_q - 1'b1;
               if (cnt_q == LEN_W'(1)) begin
                  state_q <= FINISH;
                  done_q  <= 1'b1;
               end
            end
            FINISH: state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   assign r_en      = (state_q == READ);
   assign r_addr    = addr_q;
   assign out_valid = valid_q;
   assign out_data  = r_data;
   assign cfg.busy  = (state_q == READ);
   assign cfg.done  = done_q;

   a_read_with_count: assert property (
      @(posedge r_clk) disable iff (!rst_n)
      r_en |-> (cnt_q != '0)
   ) else $error("byte_reader: read issued with no bytes left");

   a_stream_drained: assert property (
      @(posedge r_clk) disable iff (!rst_n)
      (state_q == IDLE && $past(state_q) != IDLE) |=> !out_valid
   ) else $error("byte_reader: byte emitted after return to idle");

endmodule

`default_nettype wire

//--- design/buf_regs.sv
`timescale 1ns/10ps
`default_nettype none

module buf_regs (
   input  logic                                r_clk,
   input  logic                                rst_n,
   input  logic                                cfg_we,
   input  buf_regs_pkg::reg_addr_e             cfg_addr,
   input  logic [buf_regs_pkg::CFG_DATA_W-1:0] cfg_wdata,
   output logic [buf_regs_pkg::CFG_DATA_W-1:0] cfg_rdata,
   cfg_if.regs                                 cfg
);
   import buf_pkg::*;
   import buf_regs_pkg::*;

   logic [R_ADDR_W-1:0] base_q;
   logic [LEN_W-1:0]    len_q;
   logic                start_q;

   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         base_q  <= '0;
         len_q   <= '0;
         start_q <= 1'b0;
      end else begin
         // single cycle pulse per ctrl write
         start_q <= cfg_we && (cfg_addr == REG_CTRL) && cfg_wdata[CTRL_START_BIT];
         if (cfg_we && (cfg_addr == REG_BASE)) begin
            base_q <= cfg_wdata[R_ADDR_W-1:0];
         end
         if (cfg_we && (cfg_addr == REG_LEN)) begin
            len_q <= cfg_wdata[LEN_W-1:0];
         end
      end
   end

   assign cfg.start = start_q;
   assign cfg.base  = base_q;
   assign cfg.len   = len_q;

   always_comb begin
      cfg_rdata = '0;
      case (cfg_addr)
         REG_BASE: cfg_rdata = CFG_DATA_W'(base_q);
         REG_LEN:  cfg_rdata = CFG_DATA_W'(len_q);
         REG_STATUS: begin
            cfg_rdata[STAT_BUSY_BIT] = cfg.busy;
            cfg_rdata[STAT_DONE_BIT] = cfg.done;
         end
         // ctrl is write only
         default:  cfg_rdata = '0;
      endcase
   end

   a_start_pulse: assert property (
      @(posedge r_clk) disable iff (!rst_n)
      cfg.start |=> !cfg.start
   ) else $error("buf_regs: start held longer than one cycle");

endmodule

`default_nettype wire

//--- design/cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cfg_if;
   import buf_pkg::*;

   logic                start;
   logic [R_ADDR_W-1:0] base;
   logic [LEN_W-1:0]    len;
   logic                busy;
   logic                done;

   modport regs (
      output start, base, len,
      input  busy, done
   );

   modport reader (
      input  start, base, len,
      output busy, done
   );

endinterface

`default_nettype wire

//--- design/asym_ram.sv
`timescale 1ns/10ps
`default_nettype none

module asym_ram #(
   parameter int W_DATA_W = buf_pkg::W_DATA_W,
   parameter int W_ADDR_W = buf_pkg::W_ADDR_W,
   parameter int R_DATA_W = buf_pkg::R_DATA_W,
   parameter int R_ADDR_W = buf_pkg::R_ADDR_W
) (
   input  logic                r_clk,
   input  logic                rst_n,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // block geometry follows the narrower side
   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MAXADDR_W = (W_ADDR_W > R_ADDR_W) ? W_ADDR_W : R_ADDR_W;
   localparam int MINADDR_W = (W_ADDR_W < R_ADDR_W) ? W_ADDR_W : R_ADDR_W;
   localparam int N         = MAXDATA_W / MINDATA_W;
   localparam int SEL_W     = MAXADDR_W - MINADDR_W;

   logic [N-1:0]           en_wr;
   logic [MINDATA_W-1:0]   data_wr [N];
   logic [MINDATA_W-1:0]   data_rd [N];
   logic [MINADDR_W-1:0]   blk_w_addr;
   logic [MINADDR_W-1:0]   blk_r_addr;

   // upper address bits index the word inside each block
   assign blk_w_addr = w_addr[W_ADDR_W-1 -: MINADDR_W];
   assign blk_r_addr = r_addr[R_ADDR_W-1 -: MINADDR_W];

   for (genvar i = 0; i < N; i++) begin : g_blk
      simple_dp_ram #(
         .DATA_W (MINDATA_W),
         .ADDR_W (MINADDR_W)
      ) ram_inst (
         .r_clk  (r_clk),
         .w_en   (en_wr[i]),
         .w_addr (blk_w_addr),
         .w_data (data_wr[i]),
         .r_en   (r_en),
         .r_addr (blk_r_addr),
         .r_data (data_rd[i])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wide_write
      logic [SEL_W-1:0] sel_q;

      // all blocks take their slice of the word
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = w_en;
            data_wr[j] = w_data[j*MINDATA_W +: MINDATA_W];
         end
      end

      // low read bits pick the block, aligned with the read latency
      always_ff @(posedge r_clk or negedge rst_n) begin
         if (!rst_n) begin
            sel_q <= '0;
         end else if (r_en) begin
            sel_q <= r_addr[SEL_W-1:0];
         end
      end

      always_comb begin
         r_data = data_rd[sel_q];
      end
   end else begin : g_narrow_write
      // one block per narrow word, chosen by low write bits
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = w_en && (w_addr[SEL_W-1:0] == SEL_W'(j));
            data_wr[j] = w_data[MINDATA_W-1:0];
         end
      end

      // wide read gathers every block
      always_comb begin
         for (int k = 0; k < N; k++) begin
            r_data[k*MINDATA_W +: MINDATA_W] = data_rd[k];
         end
      end
   end

   a_w_addr_known: assert property (
      @(posedge r_clk) disable iff (!rst_n)
      w_en |-> !$isunknown(w_addr)
   ) else $error("asym_ram: write with unknown address");

endmodule

`default_nettype wire

//--- design/simple_dp_ram.sv
`timescale 1ns/10ps
`default_nettype none

module simple_dp_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 6
) (
   input  logic              r_clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
      // registered read port
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

//--- design/buf_regs_pkg.sv
`default_nettype none

package buf_regs_pkg;

   localparam int CFG_ADDR_W = 2;
   localparam int CFG_DATA_W = 8;

   typedef enum logic [CFG_ADDR_W-1:0] {
      REG_CTRL   = 2'd0,
      REG_BASE   = 2'd1,
      REG_LEN    = 2'd2,
      REG_STATUS = 2'd3
   } reg_addr_e;

   // ctrl and status bit positions
   localparam int CTRL_START_BIT = 0;
   localparam int STAT_BUSY_BIT  = 0;
   localparam int STAT_DONE_BIT  = 1;

endpackage

`default_nettype wire

//--- design/buf_pkg.sv
`default_nettype none

package buf_pkg;

   // host side word port
   localparam int W_DATA_W = 16;
   localparam int W_ADDR_W = 6;

   // byte stream side
   localparam int R_DATA_W = 8;
   localparam int R_ADDR_W = 7;

   // stream length in bytes, wraps the memory above 128
   localparam int LEN_W = 8;

endpackage

`default_nettype wire
